//--- frontend_pkg.sv
`default_nettype none

package frontend_pkg;

  // instruction field positions
  localparam int RD_LSB    = 0;
  localparam int RJ_LSB    = 5;
  localparam int RK_LSB    = 10;
  localparam int REG_W     = 5;
  localparam int OPC17_LSB = 15;
  localparam int OPC10_LSB = 22;
  localparam int OPC6_LSB  = 26;
  localparam int IMM_W     = 26;

  // 17-bit major opcodes, inst[31:15]
  localparam logic [16:0] OPC_ADDW  = 17'h00020;
  localparam logic [16:0] OPC_IDLE  = 17'h00c91;

  // 10-bit major opcodes, inst[31:22]
  localparam logic [9:0]  OPC_ADDIW = 10'h00a;
  localparam logic [9:0]  OPC_LDW   = 10'h0a2;
  localparam logic [9:0]  OPC_STW   = 10'h0a6;

  // branch opcodes are only 6 bits wide, inst[31:26]
  localparam logic [5:0]  OPC_BEQ   = 6'h16;
  localparam logic [5:0]  OPC_BL    = 6'h15;

  typedef enum logic [2:0] {
    OP_ADDW,
    OP_ADDIW,
    OP_LDW,
    OP_STW,
    OP_BEQ,
    OP_BL,
    OP_IDLE,
    OP_INVALID
  } op_e;

  // register 0 means no register
  typedef struct packed {
    logic [REG_W-1:0] r0;
    logic [REG_W-1:0] r1;
    logic [REG_W-1:0] w;
  } reg_info_t;

  // one fetched word with its address
  typedef struct packed {
    logic [31:0] pc;
    logic [31:0] inst;
  } fetch_pkt_t;

  typedef struct packed {
    logic [31:0]      pc;
    logic [31:0]      inst;
    op_e              op;
    reg_info_t        reg_info;
    logic [IMM_W-1:0] imm;
  } decoded_inst_t;

  // strobes and levels coming back from the backend
  typedef struct packed {
    logic        redirect;
    logic [31:0] redirect_target;
    logic        wait_inst;
    logic        int_detect;
    logic [1:0]  issue;
  } backend_ctrl_t;

endpackage

`default_nettype wire

//--- fetch_unit.sv
`timescale 1ns/1ps
`default_nettype none

module fetch_unit #(
  parameter logic [31:0] RESET_PC = 32'h1c00_0000
) (
  input  logic                           clk,
  input  logic                           rst_n,
  input  frontend_pkg::backend_ctrl_t    ctrl_i,
  input  logic [63:0]                    imem_rdata_i,
  input  logic                           write_ready_i,
  output logic                           imem_req_o,
  output logic [31:0]                    imem_addr_o,
  output logic [1:0]                     write_num_o,
  output frontend_pkg::fetch_pkt_t [1:0] write_data_o
);

  logic [31:0] pc_q;
  logic [31:0] req_pc_q;
  logic        inflight_q;
  logic        idle_lock_q;
  logic        fetch_en_q;
  logic        stall;
  logic        odd_start;
  logic [1:0]  lane_valid;
  logic [31:0] line_base;

  // wait blocks fetch, an interrupt releases it
  always_ff @(posedge clk) begin
    if (!rst_n) begin
      idle_lock_q <= 1'b0;
    end else if (ctrl_i.wait_inst && !ctrl_i.int_detect) begin
      idle_lock_q <= 1'b1;
    end else if (ctrl_i.int_detect) begin
      idle_lock_q <= 1'b0;
    end
  end

  // keeps the request quiet in the first cycle out of reset
  always_ff @(posedge clk) begin
    if (!rst_n) begin
      fetch_en_q <= 1'b0;
    end else begin
      fetch_en_q <= 1'b1;
    end
  end

  assign stall       = !fetch_en_q || !write_ready_i || idle_lock_q || ctrl_i.redirect;
  assign imem_req_o  = !stall;
  assign imem_addr_o = {pc_q[31:3], 3'b000};

  // fall-through only, no prediction
  always_ff @(posedge clk) begin
    if (!rst_n) begin
      pc_q <= RESET_PC;
    end else if (ctrl_i.redirect) begin
      pc_q <= ctrl_i.redirect_target;
    end else if (imem_req_o) begin
      pc_q <= {pc_q[31:3] + 29'd1, 3'b000};
    end
  end

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      inflight_q <= 1'b0;
    end else begin
      inflight_q <= imem_req_o;
    end
  end

  // bit 2 of this pc tells whether lane 0 is wanted
  always_ff @(posedge clk) begin
    if (imem_req_o) begin
      req_pc_q <= pc_q;
    end
  end

  assign line_base = {req_pc_q[31:3], 3'b000};
  assign odd_start = req_pc_q[2];

  // a response landing on a redirect is dropped
  assign lane_valid  = {1'b1, !odd_start} & {2{inflight_q && !ctrl_i.redirect}};
  assign write_num_o = {1'b0, lane_valid[0]} + {1'b0, lane_valid[1]};

  // compact: lane 1 moves down when lane 0 is skipped
  assign write_data_o[0].pc   = odd_start ? (line_base | 32'd4) : line_base;
  assign write_data_o[0].inst = odd_start ? imem_rdata_i[63:32] : imem_rdata_i[31:0];
  assign write_data_o[1].pc   = line_base | 32'd4;
  assign write_data_o[1].inst = imem_rdata_i[63:32];

endmodule

`default_nettype wire

//--- inst_fifo.sv
`timescale 1ns/1ps
`default_nettype none

module inst_fifo #(
  parameter int  FIFO_DEPTH = 16,
  parameter type entry_t    = logic [63:0]
) (
  input  logic             clk,
  input  logic             rst_n,
  input  logic             flush_i,
  input  logic [1:0]       write_num_i,
  input  entry_t [1:0]     write_data_i,
  input  logic [1:0]       read_num_i,
  output logic             write_ready_o,
  output logic [1:0]       read_valid_o,
  output entry_t [1:0]     read_data_o
);

  localparam int PTR_W = $clog2(FIFO_DEPTH);

  // room for one request in flight plus the one going out now
  localparam logic [PTR_W:0] READY_LIMIT = (PTR_W + 1)'(FIFO_DEPTH - 4);

  entry_t           mem_q [FIFO_DEPTH];
  logic [PTR_W-1:0] wr_ptr_q;
  logic [PTR_W-1:0] rd_ptr_q;
  logic [PTR_W:0]   count_q;
  logic [PTR_W-1:0] wr_ptr_nxt;
  logic [PTR_W-1:0] rd_ptr_nxt;
  logic             wr_one;
  logic             wr_two;

  // second slot of each port, wraps with the pointer
  assign wr_ptr_nxt = wr_ptr_q + PTR_W'(1);
  assign rd_ptr_nxt = rd_ptr_q + PTR_W'(1);

  assign wr_one = !flush_i && (write_num_i != 2'd0);
  assign wr_two = !flush_i && (write_num_i == 2'd2);

  always_ff @(posedge clk) begin
    if (wr_one) begin
      mem_q[wr_ptr_q] <= write_data_i[0];
    end
    if (wr_two) begin
      mem_q[wr_ptr_nxt] <= write_data_i[1];
    end
  end

  // flush drops everything, including this cycle's writes
  always_ff @(posedge clk) begin
    if (!rst_n || flush_i) begin
      wr_ptr_q <= '0;
      rd_ptr_q <= '0;
      count_q  <= '0;
    end else begin
      wr_ptr_q <= wr_ptr_q + PTR_W'(write_num_i);
      rd_ptr_q <= rd_ptr_q + PTR_W'(read_num_i);
      count_q  <= count_q + (PTR_W + 1)'(write_num_i) - (PTR_W + 1)'(read_num_i);
    end
  end

  assign write_ready_o = (count_q <= READY_LIMIT);

  // head entries, valid bit 1 implies valid bit 0
  assign read_valid_o[0] = (count_q != '0);
  assign read_valid_o[1] = (count_q > (PTR_W + 1)'(1));
  assign read_data_o[0]  = mem_q[rd_ptr_q];
  assign read_data_o[1]  = mem_q[rd_ptr_nxt];

endmodule

`default_nettype wire

//--- inst_decoder.sv
`timescale 1ns/1ps
`default_nettype none

module inst_decoder (
  input  logic [31:0]             inst_i,
  output frontend_pkg::op_e       op_o,
  output frontend_pkg::reg_info_t reg_info_o,
  output logic [25:0]             imm_o
);

  logic [16:0] opc17;
  logic [9:0]  opc10;
  logic [5:0]  opc6;
  logic [4:0]  rk;
  logic [4:0]  rj;
  logic [4:0]  rd;

  assign opc17 = inst_i[frontend_pkg::OPC17_LSB +: 17];
  assign opc10 = inst_i[frontend_pkg::OPC10_LSB +: 10];
  assign opc6  = inst_i[frontend_pkg::OPC6_LSB +: 6];

  assign rk = inst_i[frontend_pkg::RK_LSB +: frontend_pkg::REG_W];
  assign rj = inst_i[frontend_pkg::RJ_LSB +: frontend_pkg::REG_W];
  assign rd = inst_i[frontend_pkg::RD_LSB +: frontend_pkg::REG_W];

  // raw immediate field, the backend picks its own slice
  assign imm_o = inst_i[frontend_pkg::IMM_W-1:0];

  // encodings of the subset do not overlap
  always_comb begin
    if (opc17 == frontend_pkg::OPC_ADDW) begin
      op_o = frontend_pkg::OP_ADDW;
    end else if (opc17 == frontend_pkg::OPC_IDLE) begin
      op_o = frontend_pkg::OP_IDLE;
    end else if (opc10 == frontend_pkg::OPC_ADDIW) begin
      op_o = frontend_pkg::OP_ADDIW;
    end else if (opc10 == frontend_pkg::OPC_LDW) begin
      op_o = frontend_pkg::OP_LDW;
    end else if (opc10 == frontend_pkg::OPC_STW) begin
      op_o = frontend_pkg::OP_STW;
    end else if (opc6 == frontend_pkg::OPC_BEQ) begin
      op_o = frontend_pkg::OP_BEQ;
    end else if (opc6 == frontend_pkg::OPC_BL) begin
      op_o = frontend_pkg::OP_BL;
    end else begin
      op_o = frontend_pkg::OP_INVALID;
    end
  end

  // register selection per class
  always_comb begin
    reg_info_o = '0;
    case (op_o)
      frontend_pkg::OP_ADDW: begin
        reg_info_o.r0 = rk;
        reg_info_o.r1 = rj;
        reg_info_o.w  = rd;
      end
      frontend_pkg::OP_ADDIW, frontend_pkg::OP_LDW: begin
        reg_info_o.r1 = rj;
        reg_info_o.w  = rd;
      end
      // store data and the second compare operand sit in rd
      frontend_pkg::OP_STW, frontend_pkg::OP_BEQ: begin
        reg_info_o.r0 = rd;
        reg_info_o.r1 = rj;
      end
      frontend_pkg::OP_BL: begin
        reg_info_o.w = 5'd1;
      end
      default: begin
        reg_info_o = '0;
      end
    endcase
  end

endmodule

`default_nettype wire

//--- issue_stage.sv
`timescale 1ns/1ps
`default_nettype none

module issue_stage (
  input  logic                              clk,
  input  logic                              rst_n,
  input  frontend_pkg::backend_ctrl_t       ctrl_i,
  input  logic [1:0]                        read_valid_i,
  input  frontend_pkg::fetch_pkt_t [1:0]    read_data_i,
  output logic [1:0]                        read_num_o,
  output logic [1:0]                        inst_valid_o,
  output frontend_pkg::decoded_inst_t [1:0] inst_o
);

  frontend_pkg::op_e                 dec_op  [2];
  frontend_pkg::reg_info_t           dec_reg [2];
  logic [25:0]                       dec_imm [2];
  frontend_pkg::decoded_inst_t [1:0] head_dec;
  logic [1:0]                        head_valid;
  logic [1:0]                        keep;
  logic [1:0]                        valid_q;
  logic [1:0]                        valid_nxt;
  frontend_pkg::decoded_inst_t [1:0] slot_q;
  frontend_pkg::decoded_inst_t [1:0] slot_nxt;

  for (genvar p = 0; p < 2; p++) begin : g_dec
    inst_decoder u_inst_decoder (
      .inst_i     (read_data_i[p].inst),
      .op_o       (dec_op[p]),
      .reg_info_o (dec_reg[p]),
      .imm_o      (dec_imm[p])
    );

    always_comb begin
      head_dec[p].pc       = read_data_i[p].pc;
      head_dec[p].inst     = read_data_i[p].inst;
      head_dec[p].op       = dec_op[p];
      head_dec[p].reg_info = dec_reg[p];
      head_dec[p].imm      = dec_imm[p];
    end
  end

  // nothing is taken from a FIFO that is being flushed
  assign head_valid = read_valid_i & {2{!ctrl_i.redirect}};
  assign keep       = valid_q & ~ctrl_i.issue;

  always_comb begin
    slot_nxt   = slot_q;
    valid_nxt  = 2'b00;
    read_num_o = 2'd0;
    // drop issued slots, slot 1 slides down if slot 0 left
    case (keep)
      2'b11: valid_nxt = 2'b11;
      2'b01: valid_nxt = 2'b01;
      2'b10: begin
        slot_nxt[0] = slot_q[1];
        valid_nxt   = 2'b01;
      end
      default: valid_nxt = 2'b00;
    endcase
    // refill in order from the head
    if (!valid_nxt[0]) begin
      slot_nxt   = head_dec;
      valid_nxt  = head_valid;
      read_num_o = {1'b0, head_valid[0]} + {1'b0, head_valid[1]};
    end else if (!valid_nxt[1] && head_valid[0]) begin
      slot_nxt[1]  = head_dec[0];
      valid_nxt[1] = 1'b1;
      read_num_o   = 2'd1;
    end
  end

  always_ff @(posedge clk) begin
    if (!rst_n || ctrl_i.redirect) begin
      valid_q <= 2'b00;
    end else begin
      valid_q <= valid_nxt;
    end
    slot_q <= slot_nxt;
  end

  assign inst_valid_o = valid_q;
  assign inst_o       = slot_q;

endmodule

`default_nettype wire

//--- core_frontend.sv
`timescale 1ns/1ps
`default_nettype none

module core_frontend #(
  parameter logic [31:0] RESET_PC   = 32'h1c00_0000,
  parameter int          FIFO_DEPTH = 16
) (
  input  logic                              clk,
  input  logic                              rst_n,
  input  frontend_pkg::backend_ctrl_t       ctrl_i,
  input  logic [63:0]                       imem_rdata_i,
  output logic                              imem_req_o,
  output logic [31:0]                       imem_addr_o,
  output logic [1:0]                        inst_valid_o,
  output frontend_pkg::decoded_inst_t [1:0] inst_o
);

  logic                           write_ready;
  logic [1:0]                     write_num;
  frontend_pkg::fetch_pkt_t [1:0] write_data;
  logic [1:0]                     read_valid;
  logic [1:0]                     read_num;
  frontend_pkg::fetch_pkt_t [1:0] read_data;

  fetch_unit #(
    .RESET_PC (RESET_PC)
  ) u_fetch_unit (
    .clk           (clk),
    .rst_n         (rst_n),
    .ctrl_i        (ctrl_i),
    .imem_rdata_i  (imem_rdata_i),
    .write_ready_i (write_ready),
    .imem_req_o    (imem_req_o),
    .imem_addr_o   (imem_addr_o),
    .write_num_o   (write_num),
    .write_data_o  (write_data)
  );

  // redirect flushes the buffered words
  inst_fifo #(
    .FIFO_DEPTH (FIFO_DEPTH),
    .entry_t    (frontend_pkg::fetch_pkt_t)
  ) u_inst_fifo (
    .clk           (clk),
    .rst_n         (rst_n),
    .flush_i       (ctrl_i.redirect),
    .write_num_i   (write_num),
    .write_data_i  (write_data),
    .read_num_i    (read_num),
    .write_ready_o (write_ready),
    .read_valid_o  (read_valid),
    .read_data_o   (read_data)
  );

  issue_stage u_issue_stage (
    .clk          (clk),
    .rst_n        (rst_n),
    .ctrl_i       (ctrl_i),
    .read_valid_i (read_valid),
    .read_data_i  (read_data),
    .read_num_o   (read_num),
    .inst_valid_o (inst_valid_o),
    .inst_o       (inst_o)
  );

endmodule

`default_nettype wire

//--- tb_core_frontend.sv
`timescale 1ns/1ps
`default_nettype none

module tb_core_frontend;

  localparam logic [31:0] RESET_PC   = 32'h1c00_0000;
  localparam int          FIFO_DEPTH = 16;
  localparam int          MEM_WORDS  = 1024;
  localparam int          N_INST     = 140;

  logic                              clk;
  logic                              rst_n;
  frontend_pkg::backend_ctrl_t       ctrl_i;
  logic [63:0]                       imem_rdata_i;
  logic                              imem_req_o;
  logic [31:0]                       imem_addr_o;
  logic [1:0]                        inst_valid_o;
  frontend_pkg::decoded_inst_t [1:0] inst_o;

  logic [31:0]             mem_word [MEM_WORDS];
  frontend_pkg::op_e       exp_op   [MEM_WORDS];
  frontend_pkg::reg_info_t exp_reg  [MEM_WORDS];
  logic [31:0]             exp_q [$];
  logic [31:0]             next_pc;
  logic                    req_seen;
  logic [31:0]             addr_seen;
  logic [31:0]             fetch_addr;
  logic                    lock_model;
  integer                  seed;
  int                      error_count;
  int                      check_count;
  int                      issued_count;
  string                   test_name;

  core_frontend #(
    .RESET_PC   (RESET_PC),
    .FIFO_DEPTH (FIFO_DEPTH)
  ) u_core_frontend (
    .clk          (clk),
    .rst_n        (rst_n),
    .ctrl_i       (ctrl_i),
    .imem_rdata_i (imem_rdata_i),
    .imem_req_o   (imem_req_o),
    .imem_addr_o  (imem_addr_o),
    .inst_valid_o (inst_valid_o),
    .inst_o       (inst_o)
  );

  always #10 clk = ~clk;

  function automatic int word_index(input logic [31:0] addr);
    return int'(((addr - RESET_PC) >> 2) & (MEM_WORDS - 1));
  endfunction

  // one class per word with registers and immediates mixed from the whole index
  task automatic fill_memory();
    logic [4:0]  rd;
    logic [4:0]  rj;
    logic [4:0]  rk;
    logic [11:0] si12;
    logic [31:0] w;
    frontend_pkg::reg_info_t ri;
    for (int i = 0; i < MEM_WORDS; i++) begin
      rd   = 5'(i ^ (i >> 5));
      rj   = 5'((i >> 1) ^ (i >> 6));
      rk   = 5'((i >> 2) + (i >> 7));
      si12 = 12'(i * 37);
      ri   = '0;
      case (i % 8)
        0: begin
          w  = {frontend_pkg::OPC_ADDW, rk, rj, rd};
          ri = '{r0: rk, r1: rj, w: rd};
        end
        1: begin
          w  = {frontend_pkg::OPC_ADDIW, si12, rj, rd};
          ri = '{r0: 5'd0, r1: rj, w: rd};
        end
        2: begin
          w  = {frontend_pkg::OPC_LDW, si12, rj, rd};
          ri = '{r0: 5'd0, r1: rj, w: rd};
        end
        3: begin
          w  = {frontend_pkg::OPC_STW, si12, rj, rd};
          ri = '{r0: rd, r1: rj, w: 5'd0};
        end
        4: begin
          w  = {frontend_pkg::OPC_BEQ, 16'(i * 11), rj, rd};
          ri = '{r0: rd, r1: rj, w: 5'd0};
        end
        5: begin
          w  = {frontend_pkg::OPC_BL, 26'(i * 101)};
          ri = '{r0: 5'd0, r1: 5'd0, w: 5'd1};
        end
        6: w = {frontend_pkg::OPC_IDLE, 15'(i)};
        default: w = {6'h3f, 26'(i * 7)};
      endcase
      mem_word[i] = w;
      exp_op[i]   = frontend_pkg::op_e'(3'(i % 8));
      exp_reg[i]  = ri;
    end
  endtask

  task automatic report_fail(input string field, input logic [31:0] exp_val,
                             input logic [31:0] act_val);
    error_count++;
    $display("Fail %s %s: expected %h actual %h", test_name, field, exp_val, act_val);
  endtask

  // slot k must hold the k-th oldest instruction not yet issued
  task automatic check_slots();
    int idx;
    while (exp_q.size() < 2) begin
      exp_q.push_back(next_pc);
      next_pc = next_pc + 32'd4;
    end
    for (int k = 0; k < 2; k++) begin
      if (inst_valid_o[k]) begin
        idx = word_index(exp_q[k]);
        check_count++;
        assert (inst_o[k].pc == exp_q[k])
          else report_fail("pc", exp_q[k], inst_o[k].pc);
        assert (inst_o[k].inst == mem_word[idx])
          else report_fail("inst", mem_word[idx], inst_o[k].inst);
        assert (inst_o[k].op == exp_op[idx])
          else report_fail("op", 32'(exp_op[idx]), 32'(inst_o[k].op));
        assert (inst_o[k].reg_info == exp_reg[idx])
          else report_fail("reg_info", 32'(exp_reg[idx]), 32'(inst_o[k].reg_info));
        assert (inst_o[k].imm == mem_word[idx][25:0])
          else report_fail("imm", 32'(mem_word[idx][25:0]), 32'(inst_o[k].imm));
      end
    end
  endtask

  // one cycle of backend activity with one-cycle strobes
  task automatic run_cycle(input logic allow_issue);
    logic [1:0] strobe;
    @(negedge clk);
    check_slots();
    strobe = 2'b00;
    if (allow_issue) begin
      strobe = 2'($random(seed)) & inst_valid_o;
    end
    ctrl_i       = '0;
    ctrl_i.issue = strobe;
    if (strobe[1]) begin
      exp_q.delete(1);
    end
    if (strobe[0]) begin
      exp_q.delete(0);
    end
    issued_count = issued_count + int'(strobe[0]) + int'(strobe[1]);
  endtask

  task automatic run_until(input int count);
    int goal;
    goal = issued_count + count;
    while (issued_count < goal) begin
      run_cycle(1'b1);
    end
  endtask

  task automatic redirect_to(input logic [31:0] target);
    run_cycle(1'b0);
    ctrl_i.redirect        = 1'b1;
    ctrl_i.redirect_target = target;
    exp_q.delete();
    next_pc = target;
  endtask

  // memory answers one cycle after the request
  always @(posedge clk) begin
    req_seen  <= imem_req_o;
    addr_seen <= imem_addr_o;
  end

  always @(negedge clk) begin
    if (req_seen === 1'b1) begin
      imem_rdata_i = {mem_word[word_index(addr_seen + 32'd4)], mem_word[word_index(addr_seen)]};
    end
  end

  // expected address of the next request, 8-byte steps from reset pc or target
  always @(posedge clk) begin
    if (!rst_n) begin
      fetch_addr <= RESET_PC;
    end else if (ctrl_i.redirect) begin
      fetch_addr <= {ctrl_i.redirect_target[31:3], 3'b000};
    end else if (imem_req_o) begin
      fetch_addr <= fetch_addr + 32'd8;
    end
  end

  // expected idle lock state
  always @(posedge clk) begin
    if (!rst_n) begin
      lock_model <= 1'b0;
    end else if (ctrl_i.int_detect) begin
      lock_model <= 1'b0;
    end else if (ctrl_i.wait_inst) begin
      lock_model <= 1'b1;
    end
  end

  slot_order: assert property (@(posedge clk) disable iff (!rst_n)
    inst_valid_o[1] |-> inst_valid_o[0])
    else begin
      error_count++;
      $display("slot 1 was valid without slot 0 during %s", test_name);
    end

  no_fetch_when_idle: assert property (@(posedge clk) disable iff (!rst_n)
    lock_model |-> !imem_req_o)
    else begin
      error_count++;
      $display("instruction request made while idle lock was set during %s", test_name);
    end

  fetch_address: assert property (@(posedge clk) disable iff (!rst_n)
    imem_req_o |-> (imem_addr_o == fetch_addr))
    else begin
      error_count++;
      $display("Fail %s imem_addr_o: expected %h actual %h", test_name,
               $sampled(fetch_addr), $sampled(imem_addr_o));
    end

  initial begin
    repeat (N_INST * 20 + 2000) @(posedge clk);
    $display("watchdog expired before all tests finished, stuck in %s", test_name);
    $display("ERRORS FOUND");
    $finish;
  end

  initial begin
    clk          = 1'b0;
    rst_n        = 1'b0;
    ctrl_i       = '0;
    imem_rdata_i = '0;
    seed         = 10570;
    error_count  = 0;
    check_count  = 0;
    issued_count = 0;
    next_pc      = RESET_PC;
    test_name    = "reset";
    fill_memory();
    repeat (4) @(negedge clk);
    assert (!imem_req_o)
      else report_fail("imem_req_o", 32'd0, 32'(imem_req_o));
    assert (inst_valid_o == 2'b00)
      else report_fail("inst_valid_o", 32'd0, 32'(inst_valid_o));
    rst_n = 1'b1;

    test_name = "order";
    run_until(60);

    // FIFO fills and fetch must stop while nothing issues
    test_name = "backpressure";
    repeat (40) begin
      run_cycle(1'b0);
    end
    assert (!imem_req_o)
      else report_fail("imem_req_o", 32'd0, 32'(imem_req_o));
    assert (inst_valid_o == 2'b11)
      else report_fail("inst_valid_o", 32'd3, 32'(inst_valid_o));
    run_until(20);

    test_name = "redirect aligned";
    redirect_to(RESET_PC + 32'h200);
    run_until(20);

    test_name = "redirect odd";
    redirect_to(RESET_PC + 32'h304);
    run_until(20);

    test_name = "idle";
    run_cycle(1'b1);
    ctrl_i.wait_inst = 1'b1;
    repeat (30) begin
      run_cycle(1'b1);
    end
    assert (!imem_req_o)
      else report_fail("imem_req_o", 32'd0, 32'(imem_req_o));
    run_cycle(1'b1);
    ctrl_i.int_detect = 1'b1;
    run_until(20);
    run_cycle(1'b0);

    $display("checked slots: %0d, errors: %0d", check_count, error_count);
    if (error_count == 0) begin
      $display("NO ERRORS");
    end else begin
      $display("ERRORS FOUND");
    end
    $finish;
  end

endmodule

`default_nettype wire

//--- core_frontend.f
frontend_pkg.sv
fetch_unit.sv
inst_fifo.sv
inst_decoder.sv
issue_stage.sv
core_frontend.sv
tb_core_frontend.sv
